// ==== flist.f ====
verilog/spi_cmd_pkg.sv
verilog/spi_frame_engine.sv
verilog/spi_cmd_fifo.sv
verilog/spi_apb_regs.sv
verilog/spi_cmd_top.sv
test/spi_dev_model.sv
test/spi_cmd_checker.sv
test/spi_cmd_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e

verilator --binary --timing --assert --timescale 1ns/100ps \
  -f flist.f --top-module spi_cmd_tb -o spi_cmd_sim

./obj_dir/spi_cmd_sim | tee sim.log

if grep -qx "No errors" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi

// ==== test/spi_cmd_tb.sv ====
`timescale 1ns/100ps

module spi_cmd_tb;

  localparam int FIFO_DEPTH = 4;
  localparam int CLK_HALF   = 4;
  localparam int READ_GAP   = 100;
  localparam int N_CMDS     = 52;
  localparam int TIMEOUT    = N_CMDS * (READ_GAP + 40 * CLK_HALF) + 2000;

  localparam logic [31:0] BUSY_W    = 32'd1 << spi_cmd_pkg::ST_BUSY;
  localparam logic [31:0] FULL_W    = 32'd1 << spi_cmd_pkg::ST_FULL;
  localparam logic [31:0] EMPTY_W   = 32'd1 << spi_cmd_pkg::ST_EMPTY;
  localparam logic [31:0] RVALID_W  = 32'd1 << spi_cmd_pkg::ST_RVALID;
  localparam logic [31:0] OVERRUN_W = 32'd1 << spi_cmd_pkg::ST_OVERRUN;

  logic                   clk = 1'b0;
  logic                   rst_n;
  logic                   psel;
  logic                   penable;
  logic                   pwrite;
  spi_cmd_pkg::apb_addr_t paddr;
  logic [31:0]            pwdata;
  logic [31:0]            prdata;
  logic                   pslverr;
  logic                   sclk;
  logic                   cs;
  logic                   mosi;
  logic                   miso;
  spi_cmd_pkg::byte_t     shadow [8] = '{default: 8'h00}; // image of the peripheral registers
  int                     seed = 13;

  spi_cmd_top #(
    .FIFO_DEPTH (FIFO_DEPTH),
    .CLK_HALF   (CLK_HALF),
    .READ_GAP   (READ_GAP)
  ) dut_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pslverr (pslverr),
    .sclk    (sclk),
    .cs      (cs),
    .mosi    (mosi),
    .miso    (miso)
  );

  spi_dev_model dev_i (
    .sclk (sclk),
    .cs   (cs),
    .mosi (mosi),
    .miso (miso)
  );

  spi_cmd_checker #(
    .READ_GAP (READ_GAP)
  ) chk_i (
    .clk   (clk),
    .rst_n (rst_n),
    .sclk  (sclk),
    .cs    (cs),
    .mosi  (mosi)
  );

  always #4 clk = ~clk;

  function automatic spi_cmd_pkg::byte_t expected_rdata(input spi_cmd_pkg::reg_addr_t addr);
    return shadow[addr];
  endfunction

  task automatic apb_access(input logic wr, input spi_cmd_pkg::apb_addr_t addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err);
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= wr;
    paddr   <= addr;
    pwdata  <= wdata;
    @(posedge clk);
    penable <= 1'b1;
    @(negedge clk);
    rdata = prdata; // prdata and pslverr are settled in the access phase
    err   = pslverr;
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic apb_write(input spi_cmd_pkg::apb_addr_t addr, input logic [31:0] data,
                           input logic exp_err);
    logic [31:0] rd_unused;
    logic        err;
    apb_access(1'b1, addr, data, rd_unused, err);
    chk_i.compare_value("pslverr", {31'd0, err}, {31'd0, exp_err});
  endtask

  task automatic apb_read(input spi_cmd_pkg::apb_addr_t addr, output logic [31:0] data);
    logic err;
    apb_access(1'b0, addr, 32'd0, data, err);
    chk_i.compare_value("pslverr", {31'd0, err}, 32'd0);
  endtask

  task automatic send_cmd(input spi_cmd_pkg::cmd_t cmd);
    chk_i.expect_cmd(cmd);
    apb_write(spi_cmd_pkg::CMD_OFS, {20'd0, cmd}, 1'b0);
    if (cmd[spi_cmd_pkg::CMD_WR_BIT])
      shadow[cmd[10:8]] = cmd[7:0];
  endtask

  task automatic wait_idle(output logic [31:0] status);
    do
      apb_read(spi_cmd_pkg::STATUS_OFS, status);
    while (status[spi_cmd_pkg::ST_BUSY] || !status[spi_cmd_pkg::ST_EMPTY]);
  endtask

  task automatic read_check(input spi_cmd_pkg::reg_addr_t addr);
    logic [31:0] status;
    logic [31:0] data;
    send_cmd({1'b0, addr, 8'h00});
    wait_idle(status);
    chk_i.compare_value("status", status, EMPTY_W | RVALID_W);
    apb_read(spi_cmd_pkg::RDATA_OFS, data);
    chk_i.compare_value("rdata", data, {24'd0, expected_rdata(addr)});
  endtask

  initial
  begin
    logic [31:0]       rd;
    int                rnd;
    spi_cmd_pkg::cmd_t cmd;
    rst_n   <= 1'b0;
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
    paddr   <= '0;
    pwdata  <= '0;
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    chk_i.compare_value("cs", {31'd0, cs}, 32'd1);
    chk_i.compare_value("sclk", {31'd0, sclk}, 32'd0);
    apb_read(spi_cmd_pkg::STATUS_OFS, rd);
    chk_i.compare_value("status", rd, EMPTY_W);

    send_cmd(12'hA5C); // write 0x5c to register 2
    wait_idle(rd);
    read_check(3'd2);

    send_cmd(12'h811); // keeps the engine busy while the queue fills
    for (int i = 0; i < FIFO_DEPTH; i++)
      send_cmd({1'b1, 3'(i + 3), 8'(i * 17 + 1)});
    apb_read(spi_cmd_pkg::STATUS_OFS, rd);
    chk_i.compare_value("status", rd, BUSY_W | FULL_W);
    apb_write(spi_cmd_pkg::CMD_OFS, 32'h0000_0FFF, 1'b1);
    wait_idle(rd);

    send_cmd({1'b0, 3'd4, 8'h00});
    wait_idle(rd);
    send_cmd({1'b0, 3'd5, 8'h00});
    wait_idle(rd);
    chk_i.compare_value("status", rd, EMPTY_W | RVALID_W | OVERRUN_W);
    apb_read(spi_cmd_pkg::RDATA_OFS, rd);
    chk_i.compare_value("rdata", rd, {24'd0, expected_rdata(3'd5)});
    apb_read(spi_cmd_pkg::STATUS_OFS, rd);
    chk_i.compare_value("status", rd, EMPTY_W);

    repeat (40)
    begin
      rnd = $random(seed);
      cmd = rnd[11:0];
      if (cmd[spi_cmd_pkg::CMD_WR_BIT])
      begin
        send_cmd(cmd);
        wait_idle(rd);
      end
      else
        read_check(cmd[10:8]);
    end

    if (chk_i.pending_cmds() != 0)
      chk_i.note_failure("queued commands never appeared on the SPI pins");
    $display("checks: %0d frames, %0d values, %0d errors",
             chk_i.frames_done, chk_i.values_done, chk_i.error_count());
    if (chk_i.error_count() == 0)
      $display("No errors");
    else
      $display("Errors found");
    $finish;
  end

  initial
  begin
    repeat (TIMEOUT) @(posedge clk);
    $display("timeout: the run did not finish within %0d clock cycles", TIMEOUT);
    $display("checks: %0d frames, %0d values, %0d errors",
             chk_i.frames_done, chk_i.values_done, chk_i.error_count());
    $display("Errors found");
    $finish;
  end

endmodule

// ==== test/spi_cmd_checker.sv ====
`timescale 1ns/100ps

module spi_cmd_checker #(
  parameter int READ_GAP = 100
) (
  input logic clk,
  input logic rst_n,
  input logic sclk,
  input logic cs,
  input logic mosi
);

  spi_cmd_pkg::cmd_t exp_cmd [128];
  logic [6:0]        wr_ptr = 7'd0;
  logic [6:0]        rd_ptr = 7'd0;
  int                frame_errors = 0;
  int                value_errors = 0;
  int                frames_done = 0;
  int                values_done = 0;
  logic              sclk_q = 1'b0;
  logic              cs_q = 1'b1;
  logic [11:0]       sreg = 12'd0;
  int                nbits = 0;
  int                gap_cnt = 0;
  logic              rd_wait = 1'b0; // set between a read address frame and its data frame

  task automatic expect_cmd(input spi_cmd_pkg::cmd_t cmd);
    exp_cmd[wr_ptr] = cmd;
    wr_ptr = wr_ptr + 7'd1;
  endtask

  task automatic compare_value(input string name, input logic [31:0] got, input logic [31:0] want);
    values_done++;
    if (got !== want)
    begin
      $display("MISMATCH at %0t: %s got 0x%0h expected 0x%0h", $time, name, got, want);
      value_errors++;
    end
  endtask

  task automatic note_failure(input string msg);
    $display("ERROR at %0t: %s", $time, msg);
    value_errors++;
  endtask

  function automatic int pending_cmds();
    return int'(wr_ptr - rd_ptr);
  endfunction

  function automatic int error_count();
    return frame_errors + value_errors;
  endfunction

  task automatic frame_compare(input string name, input int got, input int want);
    if (got != want)
    begin
      $display("MISMATCH at %0t: %s got 0x%0h expected 0x%0h", $time, name, got, want);
      frame_errors++;
    end
  endtask

  task automatic end_frame();
    spi_cmd_pkg::cmd_t want;
    if (rd_ptr == wr_ptr)
    begin
      $display("ERROR at %0t: an SPI frame appeared with no command queued", $time);
      frame_errors++;
    end
    else
    begin
      want = exp_cmd[rd_ptr];
      if (rd_wait)
      begin
        frame_compare("read data sclk edges", nbits, 8);
        rd_wait = 1'b0;
        rd_ptr  = rd_ptr + 7'd1;
        frames_done++;
      end
      else if (want[spi_cmd_pkg::CMD_WR_BIT])
      begin
        frame_compare("write sclk edges", nbits, 12);
        frame_compare("write frame mosi", int'(sreg), int'(want));
        rd_ptr = rd_ptr + 7'd1;
        frames_done++;
      end
      else
      begin
        frame_compare("read address sclk edges", nbits, 4);
        frame_compare("read address mosi", int'(sreg[3:0]), int'(want[11:8]));
        rd_wait = 1'b1;
        gap_cnt = 1; // this sample already sees cs high
      end
    end
  endtask

  // pins are sampled half a clk cycle after the DUT updates them
  always @(negedge clk)
  begin
    if (rst_n)
    begin
      if (sclk && !sclk_q)
      begin
        if (cs)
        begin
          $display("ERROR at %0t: sclk rose while cs was high", $time);
          frame_errors++;
        end
        else
        begin
          sreg  = {sreg[10:0], mosi};
          nbits = nbits + 1;
        end
      end
      if (!cs && cs_q)
      begin
        if (rd_wait)
          frame_compare("read gap cycles", gap_cnt, READ_GAP);
        nbits = 0;
      end
      else if (cs && !cs_q)
        end_frame();
      else if (cs && rd_wait)
        gap_cnt++;
    end
    sclk_q = sclk;
    cs_q   = cs;
  end

endmodule

// ==== test/spi_dev_model.sv ====
`timescale 1ns/100ps

module spi_dev_model (
  input  logic sclk,
  input  logic cs,
  input  logic mosi,
  output logic miso
);

  spi_cmd_pkg::byte_t     regs [8] = '{default: 8'h00};
  spi_cmd_pkg::byte_t     tx_byte = 8'h00;
  spi_cmd_pkg::reg_addr_t rd_addr = 3'd0;
  logic [11:0]            rx_bits = 12'd0;
  int                     nbits = 0;
  logic                   rd_pending = 1'b0; // set from an address frame until its data frame
  logic                   sclk_q = 1'b0;
  logic                   cs_q = 1'b1;
  logic                   miso_q = 1'b0;

  assign miso = miso_q;

  always @(sclk or cs)
  begin
    if (cs !== cs_q)
    begin
      if (!cs)
      begin
        nbits = 0;
        if (rd_pending)
        begin
          tx_byte = regs[rd_addr];
          miso_q  = tx_byte[7]; // msb is ready before the first rising edge
        end
      end
      else
      begin
        if (nbits == 12 && rx_bits[11])
          regs[rx_bits[10:8]] = rx_bits[7:0];
        else if (nbits == 4 && !rx_bits[3])
        begin
          rd_pending = 1'b1;
          rd_addr    = rx_bits[2:0];
        end
        else if (nbits == 8)
          rd_pending = 1'b0;
        miso_q = 1'b0;
      end
    end
    else if (!cs && sclk !== sclk_q)
    begin
      if (sclk)
      begin
        rx_bits = {rx_bits[10:0], mosi};
        nbits   = nbits + 1;
      end
      else if (rd_pending)
      begin
        tx_byte = {tx_byte[6:0], 1'b0};
        miso_q  = tx_byte[7];
      end
    end
    cs_q   = cs;
    sclk_q = sclk;
  end

endmodule

// ==== verilog/spi_cmd_top.sv ====
`timescale 1ns/100ps

module spi_cmd_top #(
  parameter int FIFO_DEPTH = 4,
  parameter int CLK_HALF   = 4,
  parameter int READ_GAP   = 100
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   psel,
  input  logic                   penable,
  input  logic                   pwrite,
  input  spi_cmd_pkg::apb_addr_t paddr,
  input  logic [31:0]            pwdata,
  output logic [31:0]            prdata,
  output logic                   pslverr,
  output logic                   sclk,
  output logic                   cs,
  output logic                   mosi,
  input  logic                   miso
);

  logic               push;
  spi_cmd_pkg::cmd_t  push_data;
  spi_cmd_pkg::cmd_t  head;
  logic               full;
  logic               empty;
  logic               cmd_vld;
  logic               cmd_rdy;
  logic               pop;
  logic               busy;
  logic               read_vld;
  spi_cmd_pkg::byte_t read_data;

  assign cmd_vld = !empty;
  assign pop     = cmd_vld && cmd_rdy; // queue advances on the engine handshake

  spi_apb_regs regs_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .paddr     (paddr),
    .pwdata    (pwdata),
    .full      (full),
    .empty     (empty),
    .busy      (busy),
    .read_vld  (read_vld),
    .read_data (read_data),
    .prdata    (prdata),
    .pslverr   (pslverr),
    .push      (push),
    .push_data (push_data)
  );

  spi_cmd_fifo #(
    .DEPTH (FIFO_DEPTH)
  ) fifo_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .push      (push),
    .push_data (push_data),
    .pop       (pop),
    .head      (head),
    .full      (full),
    .empty     (empty)
  );

  spi_frame_engine #(
    .CLK_HALF (CLK_HALF),
    .READ_GAP (READ_GAP)
  ) engine_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (head),
    .cmd_vld   (cmd_vld),
    .miso      (miso),
    .cmd_rdy   (cmd_rdy),
    .busy      (busy),
    .sclk      (sclk),
    .cs        (cs),
    .mosi      (mosi),
    .read_vld  (read_vld),
    .read_data (read_data)
  );

endmodule

// ==== verilog/spi_apb_regs.sv ====
`timescale 1ns/100ps

module spi_apb_regs (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   psel,
  input  logic                   penable,
  input  logic                   pwrite,
  input  spi_cmd_pkg::apb_addr_t paddr,
  input  logic [31:0]            pwdata,
  input  logic                   full,
  input  logic                   empty,
  input  logic                   busy,
  input  logic                   read_vld,
  input  spi_cmd_pkg::byte_t     read_data,
  output logic [31:0]            prdata,
  output logic                   pslverr,
  output logic                   push,
  output spi_cmd_pkg::cmd_t      push_data
);

  logic               access;
  logic               hit_cmd;
  logic               hit_status;
  logic               hit_rdata;
  logic               rdata_rd;
  logic               rvalid;
  logic               overrun;
  spi_cmd_pkg::byte_t rdata_q;
  logic [31:0]        status;

  assign access     = psel && penable; // with zero wait states every access ends here
  assign hit_cmd    = (paddr == spi_cmd_pkg::CMD_OFS);
  assign hit_status = (paddr == spi_cmd_pkg::STATUS_OFS);
  assign hit_rdata  = (paddr == spi_cmd_pkg::RDATA_OFS);
  assign rdata_rd   = access && !pwrite && hit_rdata;

  assign push      = access && pwrite && hit_cmd && !full;
  assign push_data = spi_cmd_pkg::cmd_t'(pwdata[11:0]);
  assign pslverr   = access && (!(hit_cmd || hit_status || hit_rdata) ||
                                (pwrite && hit_cmd && full));

  always_comb
  begin
    status                          = '0;
    status[spi_cmd_pkg::ST_BUSY]    = busy;
    status[spi_cmd_pkg::ST_FULL]    = full;
    status[spi_cmd_pkg::ST_EMPTY]   = empty;
    status[spi_cmd_pkg::ST_RVALID]  = rvalid;
    status[spi_cmd_pkg::ST_OVERRUN] = overrun;
  end

  always_comb
  begin
    prdata = '0;
    if (psel && !pwrite)
    begin
      if (hit_status)
        prdata = status;
      else if (hit_rdata)
        prdata = {24'd0, rdata_q};
    end
  end

  // a byte arriving in the same cycle as an RDATA read is not an overrun
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rvalid  <= 1'b0;
      overrun <= 1'b0;
    end
    else
    begin
      rvalid  <= read_vld || (rvalid && !rdata_rd);
      overrun <= (read_vld && rvalid && !rdata_rd) || (overrun && !rdata_rd);
    end
  end

  always_ff @(posedge clk)
  begin
    if (read_vld)
      rdata_q <= read_data; // newest byte always wins
  end

  a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
    push |-> !full);

endmodule

// ==== verilog/spi_cmd_fifo.sv ====
`timescale 1ns/100ps

module spi_cmd_fifo #(
  parameter int DEPTH = 4
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              push,
  input  spi_cmd_pkg::cmd_t push_data,
  input  logic              pop,
  output spi_cmd_pkg::cmd_t head,
  output logic              full,
  output logic              empty
);

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  spi_cmd_pkg::cmd_t mem [DEPTH];
  logic [AW-1:0]     wr_ptr;
  logic [AW-1:0]     rd_ptr;
  logic [AW:0]       count;
  logic              wr_en;
  logic              rd_en;

  assign wr_en = push && !full;  // a refused push leaves the queue untouched
  assign rd_en = pop && !empty;
  assign full  = (count == (AW + 1)'(DEPTH));
  assign empty = (count == '0);
  assign head  = mem[rd_ptr];

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (wr_en)
        wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (rd_en)
        rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (wr_en)
      mem[wr_ptr] <= push_data;
  end

  a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n)
    pop |-> !empty);

endmodule

// ==== verilog/spi_frame_engine.sv ====
`timescale 1ns/100ps

module spi_frame_engine #(
  parameter int CLK_HALF = 4,
  parameter int READ_GAP = 100
) (
  input  logic               clk,
  input  logic               rst_n,
  input  spi_cmd_pkg::cmd_t  cmd_in,
  input  logic               cmd_vld,
  output logic               cmd_rdy,
  output logic               busy,
  output logic               sclk,
  output logic               cs,
  output logic               mosi,
  input  logic               miso,
  output logic               read_vld,
  output spi_cmd_pkg::byte_t read_data
);

  localparam int HW = (CLK_HALF > 1) ? $clog2(CLK_HALF) : 1;
  localparam int GW = (READ_GAP > 1) ? $clog2(READ_GAP + 1) : 1;

  typedef enum logic [2:0] {
    IDLE,
    LOAD,
    WR_FRAME,
    RD_ADDR,
    RD_GAP,
    RD_DATA,
    FINISH
  } state_t;

  state_t             state;
  logic [HW-1:0]      hcnt;
  logic [3:0]         bit_cnt;
  logic [3:0]         frame_bits;
  logic [GW-1:0]      gcnt;
  logic               is_wr;
  spi_cmd_pkg::cmd_t  tx_sreg;
  spi_cmd_pkg::byte_t rx_sreg;
  logic               in_frame;
  logic               half_done;
  logic               last_bit;
  logic               take_cmd;

  assign cmd_rdy   = (state == IDLE);
  assign busy      = (state != IDLE);
  assign take_cmd  = cmd_rdy && cmd_vld;
  assign in_frame  = (state == WR_FRAME) || (state == RD_ADDR) || (state == RD_DATA);
  assign half_done = (hcnt == HW'(CLK_HALF - 1));
  assign last_bit  = (bit_cnt == frame_bits - 4'd1);
  assign read_data = rx_sreg;

  always_comb
  begin
    case (state)
      WR_FRAME: frame_bits = 4'd12;
      RD_ADDR:  frame_bits = 4'd4; // flag plus address
      default:  frame_bits = 4'd8;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= IDLE;
      cs       <= 1'b1;
      sclk     <= 1'b0;
      mosi     <= 1'b0;
      read_vld <= 1'b0;
      hcnt     <= '0;
      bit_cnt  <= '0;
      gcnt     <= '0;
      is_wr    <= 1'b0;
    end
    else
    begin
      read_vld <= 1'b0;
      if (in_frame)
        hcnt <= half_done ? '0 : hcnt + 1'b1;
      case (state)
        IDLE:
        begin
          if (cmd_vld)
          begin
            is_wr <= cmd_in[spi_cmd_pkg::CMD_WR_BIT];
            cs    <= 1'b0;
            state <= LOAD;
          end
        end
        LOAD:
        begin
          mosi    <= tx_sreg[11]; // first bit gets a full half period of setup
          hcnt    <= '0;
          bit_cnt <= '0;
          state   <= is_wr ? WR_FRAME : RD_ADDR;
        end
        WR_FRAME, RD_ADDR, RD_DATA:
        begin
          if (half_done)
          begin
            if (sclk)
            begin
              sclk    <= 1'b0;
              bit_cnt <= bit_cnt + 4'd1;
              if (state != RD_DATA)
                mosi <= last_bit ? 1'b0 : tx_sreg[10];
            end
            else if (bit_cnt == frame_bits)
            begin
              cs <= 1'b1; // trailing half period is over
              if (state == RD_ADDR)
              begin
                gcnt  <= '0;
                state <= RD_GAP;
              end
              else
              begin
                read_vld <= (state == RD_DATA);
                state    <= FINISH;
              end
            end
            else
              sclk <= 1'b1;
          end
        end
        RD_GAP:
        begin
          if (gcnt == GW'(READ_GAP - 1))
          begin
            cs      <= 1'b0;
            hcnt    <= '0;
            bit_cnt <= '0;
            state   <= RD_DATA;
          end
          else
            gcnt <= gcnt + 1'b1;
        end
        FINISH:
          state <= IDLE; // guarantees cs high between commands
        default:
          state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (take_cmd)
      tx_sreg <= cmd_in;
    else if (in_frame && half_done && sclk)
      tx_sreg <= {tx_sreg[10:0], 1'b0};
    if (state == RD_DATA && half_done && !sclk && bit_cnt != frame_bits)
      rx_sreg <= {rx_sreg[6:0], miso}; // sampled as sclk rises
  end

  a_cs_idle: assert property (@(posedge clk) disable iff (!rst_n)
    (state == IDLE) |-> cs);

  a_rvld_finish: assert property (@(posedge clk) disable iff (!rst_n)
    read_vld |-> (state == FINISH) && !is_wr);

endmodule

// ==== verilog/spi_cmd_pkg.sv ====
package spi_cmd_pkg;

  typedef logic [11:0] cmd_t;      // bit 11 write flag, 10:8 address, 7:0 data
  typedef logic [2:0]  reg_addr_t;
  typedef logic [7:0]  byte_t;
  typedef logic [3:0]  apb_addr_t;

  localparam int CMD_WR_BIT = 11;

  localparam apb_addr_t CMD_OFS    = 4'h0; // write pushes a command
  localparam apb_addr_t STATUS_OFS = 4'h4;
  localparam apb_addr_t RDATA_OFS  = 4'h8; // read clears valid and overrun

  localparam int ST_BUSY    = 0;
  localparam int ST_FULL    = 1;
  localparam int ST_EMPTY   = 2;
  localparam int ST_RVALID  = 3;
  localparam int ST_OVERRUN = 4;

endpackage
